//--- run_sim.sh
#!/bin/sh
# compile and run the dispatch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wall -Wno-fatal \
    --top-module tb_dispatch -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/Vtb_dispatch > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- sim.f
+incdir+source
source/issue_pkg.sv
source/exec_pkg.sv
source/dispatch_arbiter.sv
source/packet_splitter.sv
source/lane_alu.sv
source/dispatch_top.sv
verif/tb_dispatch.sv

//--- source/dispatch_arbiter.sv
/*
  round-robin arbiter over the issue ports
  the grant is combinational and stays on one port until instr_done
  a port must hold valid and its instruction until it sees ready
  the first search after reset starts at port 0
*/
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_consts.svh"

module dispatch_arbiter (
    input  wire                    clk,
    input  wire                    reset,
    input  wire [`ISSUE_WIDTH-1:0] issue_valid,
    input  wire issue_pkg::issue_instr_t issue_instr [`ISSUE_WIDTH],
    input  wire                    instr_done,
    output logic [`ISSUE_WIDTH-1:0] issue_ready,
    output logic                   grant_valid,
    output issue_pkg::issue_instr_t grant_instr
);
    localparam int IDX_BITS = $clog2(`ISSUE_WIDTH);

    logic                locked;
    logic [IDX_BITS-1:0] lock_idx;
    logic [IDX_BITS-1:0] last_idx;
    logic [IDX_BITS-1:0] pick_idx;
    logic                pick_valid;
    logic [IDX_BITS-1:0] grant_idx;

    // search starts one past the port served last
    always_comb begin
        logic [IDX_BITS-1:0] cand;
        pick_valid = 1'b0;
        pick_idx   = '0;
        for (int k = 1; k <= `ISSUE_WIDTH; k++) begin
            cand = last_idx + IDX_BITS'(k);
            if (!pick_valid && issue_valid[cand]) begin
                pick_valid = 1'b1;
                pick_idx   = cand;
            end
        end
    end

    assign grant_idx   = locked ? lock_idx : pick_idx;
    assign grant_valid = locked || pick_valid;
    assign grant_instr = issue_instr[grant_idx];

    always_comb begin
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            issue_ready[i] = instr_done && (grant_idx == IDX_BITS'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            locked   <= 1'b0;
            lock_idx <= '0;
            last_idx <= IDX_BITS'(`ISSUE_WIDTH - 1);
        end else if (instr_done) begin
            locked   <= 1'b0;
            last_idx <= grant_idx;
        end else if (grant_valid) begin
            // hold the port while its packets are still going out
            locked   <= 1'b1;
            lock_idx <= grant_idx;
        end
    end

endmodule

`default_nettype wire

//--- source/dispatch_consts.svh
/*
  sizing of the dispatch stage
  NUM_THREADS must be a multiple of NUM_LANES, and ISSUE_WIDTH and
  EXEC_CREDITS must be powers of two of at least 2
  the ring pointers in the arbiter and lane_alu wrap by overflow
*/
`ifndef DISPATCH_CONSTS_SVH
`define DISPATCH_CONSTS_SVH

`define NUM_THREADS  8
`define NUM_LANES    2
`define XLEN         16
`define ISSUE_WIDTH  4
`define EXEC_CREDITS 2

// one warp instruction leaves as this many lane packets at most
`define NUM_PACKETS  (`NUM_THREADS / `NUM_LANES)

`define WID_BITS     4
`define PID_BITS     ($clog2(`NUM_PACKETS))

`endif

//--- source/dispatch_top.sv
/*
  operand-dispatch stage
  issue ports -> round-robin arbiter -> packet splitter -> lane_alu
  one issue port is served at a time, results leave in packet order
  ready on a port rises only in the cycle its last packet is sent
*/
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_consts.svh"

module dispatch_top (
    input  wire                     clk,
    input  wire                     reset,
    input  wire [`ISSUE_WIDTH-1:0]  issue_valid,
    input  wire issue_pkg::issue_instr_t issue_instr [`ISSUE_WIDTH],
    output logic [`ISSUE_WIDTH-1:0] issue_ready,
    output logic                    result_valid,
    output exec_pkg::lane_result_t  result,
    input  wire                     result_ready
);
    import issue_pkg::*;
    import exec_pkg::*;

    logic         grant_valid;
    issue_instr_t grant_instr;
    logic         instr_done;
    logic         pkt_valid;
    lane_packet_t pkt;
    logic         credit_return;

    dispatch_arbiter u_arbiter (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_instr (issue_instr),
        .instr_done  (instr_done),
        .issue_ready (issue_ready),
        .grant_valid (grant_valid),
        .grant_instr (grant_instr)
    );

    packet_splitter u_splitter (
        .clk           (clk),
        .reset         (reset),
        .grant_valid   (grant_valid),
        .grant_instr   (grant_instr),
        .credit_return (credit_return),
        .instr_done    (instr_done),
        .pkt_valid     (pkt_valid),
        .pkt           (pkt)
    );

    lane_alu u_alu (
        .clk           (clk),
        .reset         (reset),
        .pkt_valid     (pkt_valid),
        .pkt           (pkt),
        .result_ready  (result_ready),
        .credit_return (credit_return),
        .result_valid  (result_valid),
        .result        (result)
    );

endmodule

`default_nettype wire

//--- source/exec_pkg.sv
/*
  types on the execute side of the dispatch stage
  a packet covers NUM_LANES neighbouring threads, pid selects which group
  sop and eop mark the first and last packet sent for one instruction
*/
`default_nettype none

`include "dispatch_consts.svh"

package exec_pkg;

    typedef struct packed {
        logic [`WID_BITS-1:0]             wid;
        issue_pkg::alu_op_t               op;
        logic [`PID_BITS-1:0]             pid;
        logic                             sop;
        logic                             eop;
        logic [`NUM_LANES-1:0]            tmask;
        logic [`NUM_LANES-1:0][`XLEN-1:0] rs1;
        logic [`NUM_LANES-1:0][`XLEN-1:0] rs2;
    } lane_packet_t;

    // inactive lanes always carry a zero result
    typedef struct packed {
        logic [`WID_BITS-1:0]             wid;
        logic [`PID_BITS-1:0]             pid;
        logic                             sop;
        logic                             eop;
        logic [`NUM_LANES-1:0]            tmask;
        logic [`NUM_LANES-1:0][`XLEN-1:0] res;
    } lane_result_t;

endpackage

`default_nettype wire

//--- source/issue_pkg.sv
/*
  types seen on the issue ports
  rs1 and rs2 carry one XLEN word per thread with thread 0 in the lowest word
  tmask bit k enables thread k
*/
`default_nettype none

`include "dispatch_consts.svh"

package issue_pkg;

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_AND = 2'd2,
        OP_XOR = 2'd3
    } alu_op_t;

    // one full warp instruction as offered by an issue port
    typedef struct packed {
        logic [`WID_BITS-1:0]               wid;
        alu_op_t                            op;
        logic [`NUM_THREADS-1:0]            tmask;
        logic [`NUM_THREADS-1:0][`XLEN-1:0] rs1;
        logic [`NUM_THREADS-1:0][`XLEN-1:0] rs2;
    } issue_instr_t;

endpackage

`default_nettype wire

//--- source/lane_alu.sv
/*
  two-lane execute unit with a result queue of EXEC_CREDITS entries
  the queue has no full check, the sender's credits keep it from overflowing
  a packet written in cycle t is visible on result_valid in cycle t+1
  credit_return pulses on every output handshake
*/
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_consts.svh"

module lane_alu (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    pkt_valid,
    input  wire exec_pkg::lane_packet_t pkt,
    input  wire                    result_ready,
    output logic                   credit_return,
    output logic                   result_valid,
    output exec_pkg::lane_result_t result
);
    import issue_pkg::*;
    import exec_pkg::*;

    localparam int PTR_BITS = $clog2(`EXEC_CREDITS);
    localparam int CNT_BITS = $clog2(`EXEC_CREDITS + 1);

    lane_result_t         q_mem [`EXEC_CREDITS];
    logic [PTR_BITS-1:0]  wr_ptr;
    logic [PTR_BITS-1:0]  rd_ptr;
    logic [CNT_BITS-1:0]  count;
    lane_result_t         alu_res;
    logic                 pop;

    always_comb begin
        alu_res.wid   = pkt.wid;
        alu_res.pid   = pkt.pid;
        alu_res.sop   = pkt.sop;
        alu_res.eop   = pkt.eop;
        alu_res.tmask = pkt.tmask;
        for (int j = 0; j < `NUM_LANES; j++) begin
            if (!pkt.tmask[j]) begin
                alu_res.res[j] = '0;
            end else begin
                // sums and differences wrap at XLEN bits
                case (pkt.op)
                    OP_ADD:  alu_res.res[j] = pkt.rs1[j] + pkt.rs2[j];
                    OP_SUB:  alu_res.res[j] = pkt.rs1[j] - pkt.rs2[j];
                    OP_AND:  alu_res.res[j] = pkt.rs1[j] & pkt.rs2[j];
                    default: alu_res.res[j] = pkt.rs1[j] ^ pkt.rs2[j];
                endcase
            end
        end
    end

    assign result_valid  = (count != '0);
    assign result        = q_mem[rd_ptr];
    assign pop           = result_valid && result_ready;
    assign credit_return = pop;

    always_ff @(posedge clk) begin
        if (pkt_valid) begin
            q_mem[wr_ptr] <= alu_res;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (pkt_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({pkt_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/packet_splitter.sv
/*
  splits the granted warp instruction into lane packets
  packets whose threads are all inactive are skipped, pid order is ascending
  an all-zero mask still sends one empty packet with pid 0, sop and eop set
  one packet per cycle while a credit is held, there is no ready from the
  execute unit, so the credit count must match its queue depth
*/
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_consts.svh"

module packet_splitter (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     grant_valid,
    input  wire issue_pkg::issue_instr_t grant_instr,
    input  wire                     credit_return,
    output logic                    instr_done,
    output logic                    pkt_valid,
    output exec_pkg::lane_packet_t  pkt
);
    localparam int PID_BITS  = `PID_BITS;
    localparam int CRED_BITS = $clog2(`EXEC_CREDITS + 1);

    logic [`NUM_PACKETS-1:0] sent_mask;
    logic                    is_first;
    logic [CRED_BITS-1:0]    credits;

    logic [`NUM_PACKETS-1:0][`NUM_LANES-1:0]            pkt_tmask;
    logic [`NUM_PACKETS-1:0][`NUM_LANES-1:0][`XLEN-1:0] pkt_rs1;
    logic [`NUM_PACKETS-1:0][`NUM_LANES-1:0][`XLEN-1:0] pkt_rs2;

    logic [`NUM_PACKETS-1:0] nonempty;
    logic [`NUM_PACKETS-1:0] pending;
    logic [PID_BITS-1:0]     start_p;
    logic [PID_BITS-1:0]     end_p;
    logic                    is_last;
    logic                    send;

    // thread k = packet * NUM_LANES + lane, so the packed layouts line up
    assign pkt_tmask = grant_instr.tmask;
    assign pkt_rs1   = grant_instr.rs1;
    assign pkt_rs2   = grant_instr.rs2;

    always_comb begin
        for (int i = 0; i < `NUM_PACKETS; i++) begin
            nonempty[i] = |pkt_tmask[i];
        end
    end

    assign pending = nonempty & ~sent_mask;

    // lowest unsent packet and highest live packet, both 0 for an empty mask
    always_comb begin
        start_p = '0;
        end_p   = '0;
        for (int i = `NUM_PACKETS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                start_p = PID_BITS'(i);
            end
        end
        for (int i = 0; i < `NUM_PACKETS; i++) begin
            if (nonempty[i]) begin
                end_p = PID_BITS'(i);
            end
        end
    end

    assign is_last    = (start_p == end_p);
    assign send       = grant_valid && (credits != '0);
    assign pkt_valid  = send;
    assign instr_done = send && is_last;

    always_comb begin
        pkt.wid   = grant_instr.wid;
        pkt.op    = grant_instr.op;
        pkt.pid   = start_p;
        pkt.sop   = is_first;
        pkt.eop   = is_last;
        pkt.tmask = pkt_tmask[start_p];
        pkt.rs1   = pkt_rs1[start_p];
        pkt.rs2   = pkt_rs2[start_p];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sent_mask <= '0;
            is_first  <= 1'b1;
        end else if (instr_done) begin
            sent_mask <= '0;
            is_first  <= 1'b1;
        end else if (send) begin
            sent_mask[start_p] <= 1'b1;
            is_first           <= 1'b0;
        end
    end

    // a returned credit and a send in the same cycle cancel out
    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= CRED_BITS'(`EXEC_CREDITS);
        end else begin
            case ({credit_return, send})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_dispatch.sv
/*
  self-checking testbench for the dispatch stage
  port i only issues warp ids whose low two bits equal i, so each port owns
  its own expected queues and expectations can be queued when valid rises
  the drain counter peeks at the internal pkt_valid of the DUT
*/
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_consts.svh"

module tb_dispatch;
    import issue_pkg::*;
    import exec_pkg::*;

    localparam int WAIT_LIMIT = 4000;

    logic                    clk;
    logic                    reset;
    logic [`ISSUE_WIDTH-1:0] issue_valid;
    issue_instr_t            issue_instr [`ISSUE_WIDTH];
    logic [`ISSUE_WIDTH-1:0] issue_ready;
    logic                    result_valid;
    lane_result_t            result;
    logic                    result_ready;

    lane_result_t exp_q [1 << `WID_BITS][$];
    int           accept_order [$];
    string        test_name;
    int           err_cmp;
    int           err_other;
    int           busy;
    int           streams_left;
    int           outstanding;
    logic         in_instr;
    logic         stall_mode;

    dispatch_top DUT (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue_instr  (issue_instr),
        .issue_ready  (issue_ready),
        .result_valid (result_valid),
        .result       (result),
        .result_ready (result_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // expected results of one instruction, built from the splitting rules
    function automatic void expand_instr(input issue_instr_t ins);
        lane_result_t r;
        int           last;
        logic         first;
        int           t;
        last  = -1;
        first = 1'b1;
        for (int p = 0; p < `NUM_PACKETS; p++) begin
            if (ins.tmask[p*`NUM_LANES +: `NUM_LANES] != '0) last = p;
        end
        if (last < 0) begin
            r     = '0;
            r.wid = ins.wid;
            r.sop = 1'b1;
            r.eop = 1'b1;
            exp_q[ins.wid].push_back(r);
            return;
        end
        for (int p = 0; p <= last; p++) begin
            if (ins.tmask[p*`NUM_LANES +: `NUM_LANES] != '0) begin
                r       = '0;
                r.wid   = ins.wid;
                r.pid   = `PID_BITS'(p);
                r.sop   = first;
                r.eop   = (p == last);
                r.tmask = ins.tmask[p*`NUM_LANES +: `NUM_LANES];
                for (int l = 0; l < `NUM_LANES; l++) begin
                    t = p * `NUM_LANES + l;
                    if (ins.tmask[t]) begin
                        case (ins.op)
                            OP_ADD:  r.res[l] = ins.rs1[t] + ins.rs2[t];
                            OP_SUB:  r.res[l] = ins.rs1[t] - ins.rs2[t];
                            OP_AND:  r.res[l] = ins.rs1[t] & ins.rs2[t];
                            default: r.res[l] = ins.rs1[t] ^ ins.rs2[t];
                        endcase
                    end
                end
                exp_q[ins.wid].push_back(r);
                first = 1'b0;
            end
        end
    endfunction

    function automatic int expected_left();
        int n;
        n = 0;
        for (int w = 0; w < (1 << `WID_BITS); w++) n += exp_q[w].size();
        return n;
    endfunction

    task automatic abort_run(input string why);
        $display("ERROR in %s: %s", test_name, why);
        $display("errors: %0d mismatches, %0d other", err_cmp, err_other + 1);
        $display("Test FAILED");
        $finish;
    endtask

    task automatic send_instr(input int port, input alu_op_t op,
                              input logic [`NUM_THREADS-1:0] mask);
        issue_instr_t ins;
        int           waited;
        logic         taken;
        busy++;
        ins.wid   = `WID_BITS'(($urandom_range(0, 3) << 2) | port);
        ins.op    = op;
        ins.tmask = mask;
        for (int t = 0; t < `NUM_THREADS; t++) begin
            ins.rs1[t] = `XLEN'($urandom);
            ins.rs2[t] = `XLEN'($urandom);
        end
        @(negedge clk);
        issue_instr[port] = ins;
        issue_valid[port] = 1'b1;
        expand_instr(ins);
        waited = 0;
        taken  = 1'b0;
        while (!taken) begin
            @(posedge clk);
            taken = issue_ready[port];
            waited++;
            if (!taken && waited > WAIT_LIMIT) abort_run("issue port never became ready");
        end
        @(negedge clk);
        issue_valid[port] = 1'b0;
        busy--;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (busy != 0 || streams_left != 0 || expected_left() != 0 ||
               outstanding != 0) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) abort_run("expected results never arrived");
        end
    endtask

    // random back-pressure on the result port
    always @(negedge clk) begin
        if (stall_mode) result_ready = ($urandom_range(0, 3) != 0);
    end

    always @(posedge clk) begin
        if (!reset) begin
            for (int i = 0; i < `ISSUE_WIDTH; i++) begin
                if (issue_valid[i] && issue_ready[i]) accept_order.push_back(i);
            end
            assert ((issue_ready & ~issue_valid) == '0 && $onehot0(issue_ready)) else begin
                err_other++;
                $display("ERROR in %s: issue_ready raised on a wrong port", test_name);
            end
        end
    end

    // compare every output handshake with the head of its warp's queue
    always @(posedge clk) begin
        lane_result_t exp;
        if (!reset) begin
            outstanding = outstanding + int'(DUT.pkt_valid)
                          - int'(result_valid && result_ready);
            assert (outstanding <= `EXEC_CREDITS) else begin
                err_other++;
                $display("ERROR in %s: more results pending than credits", test_name);
            end
            if (result_valid && result_ready) begin
                assert (exp_q[result.wid].size() != 0) else begin
                    err_other++;
                    $display("ERROR in %s: result for warp %0d was not expected",
                             test_name, result.wid);
                end
                assert (result.sop == !in_instr) else begin
                    err_other++;
                    $display("ERROR in %s: packets of two instructions interleaved", test_name);
                end
                in_instr = !result.eop;
                if (exp_q[result.wid].size() != 0) begin
                    exp = exp_q[result.wid].pop_front();
                    assert (result == exp) else begin
                        err_cmp++;
                        $display("FAIL %s expected %h actual %h", test_name, exp, result);
                    end
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h30f9c5d2));
        reset        = 1'b1;
        issue_valid  = '0;
        result_ready = 1'b0;
        for (int i = 0; i < `ISSUE_WIDTH; i++) issue_instr[i] = '0;
        err_cmp      = 0;
        err_other    = 0;
        busy         = 0;
        streams_left = 0;
        outstanding  = 0;
        in_instr     = 1'b0;
        stall_mode   = 1'b0;
        test_name    = "reset";
        repeat (16) @(negedge clk);
        reset        = 1'b0;
        result_ready = 1'b1;

        test_name = "full_mask";
        for (int op = 0; op < 4; op++) send_instr(0, alu_op_t'(op), 8'hff);
        wait_idle();

        test_name = "sparse_mask";
        send_instr(1, OP_ADD, 8'b1000_0100);
        send_instr(2, OP_SUB, 8'h00);
        send_instr(3, OP_XOR, 8'b0100_0001);
        send_instr(0, OP_AND, 8'b0011_0000);
        wait_idle();

        test_name = "round_robin";
        accept_order.delete();
        fork
            send_instr(0, OP_ADD, 8'hff);
            send_instr(1, OP_SUB, 8'h0f);
            send_instr(2, OP_AND, 8'hf0);
            send_instr(3, OP_XOR, 8'h81);
        join
        wait_idle();
        assert (accept_order.size() == 4) else begin
            err_other++;
            $display("ERROR in %s: %0d instructions accepted instead of 4",
                     test_name, accept_order.size());
        end
        for (int k = 1; k < accept_order.size(); k++) begin
            assert (accept_order[k] == (accept_order[k-1] + 1) % `ISSUE_WIDTH) else begin
                err_cmp++;
                $display("FAIL %s expected %0d actual %0d", test_name,
                         (accept_order[k-1] + 1) % `ISSUE_WIDTH, accept_order[k]);
            end
        end

        test_name    = "back_pressure";
        result_ready = 1'b0;
        fork
            begin
                send_instr(1, OP_ADD, 8'hff);
                send_instr(1, OP_SUB, 8'hff);
            end
        join_none
        repeat (30) @(negedge clk);
        assert (outstanding == `EXEC_CREDITS) else begin
            err_cmp++;
            $display("FAIL %s expected %0d actual %0d", test_name, `EXEC_CREDITS,
                     outstanding);
        end
        result_ready = 1'b1;
        wait_idle();

        test_name    = "random";
        stall_mode   = 1'b1;
        streams_left = `ISSUE_WIDTH;
        for (int p = 0; p < `ISSUE_WIDTH; p++) begin
            automatic int port = p;
            fork
                begin
                    for (int n = 0; n < 40; n++) begin
                        repeat ($urandom_range(0, 3)) @(negedge clk);
                        send_instr(port, alu_op_t'($urandom_range(0, 3)),
                                   `NUM_THREADS'($urandom));
                    end
                    streams_left--;
                end
            join_none
        end
        wait_idle();
        stall_mode   = 1'b0;
        result_ready = 1'b1;

        $display("errors: %0d mismatches, %0d other", err_cmp, err_other);
        if (err_cmp == 0 && err_other == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
